//--- sim.f
+incdir+.
trdb_pkg.sv
trdb_stage_pipe.sv
trdb_itype_detector.sv
trdb_branch_map.sv
trdb_resync_counter.sv
trdb_priority.sv
trdb_packet_emitter.sv
trace_debugger.sv
tb_clk_gen.sv
tb_trace_debugger.sv

//--- tb_clk_gen.sv
// testbench clock with period 10 and active-low reset
module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset held low for the first 10 cycles, released between edges
    initial begin
        rst_no = 1'b0;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

//--- tb_trace_debugger.sv
// table-driven testbench for the trace encoder top
// reference model, packet monitor, stall check and watchdog
`include "trdb_consts.svh"

module tb_trace_debugger;
    import trdb_pkg::*;

    localparam logic [31:0] OP_NOP  = 32'h0000_0013;
    localparam logic [31:0] OP_BEQ  = 32'h0000_0063;
    localparam logic [31:0] OP_JALR = 32'h0000_8067;
    localparam logic [31:0] OP_MRET = 32'h3020_0073;

    // one retired instruction of the stimulus table
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [1:0]  priv;
        logic        exc;
        logic        intr;
    } row_t;

    logic           clk_i, rst_ni;
    trdb_inst_t     inst_i;
    trdb_trap_csr_t trap_i;
    logic           encapsulator_ready_i, lossless_trace_i;
    logic           packet_valid_o, stall_o;
    trdb_packet_t   packet_o;

    row_t           rows[$];
    trdb_packet_t   exp_q[$];
    logic [31:0]    lfsr_state;
    logic           table_ready = 1'b0;
    int             value_errs = 0;
    int             unexpected = 0;
    int             missing = 0;

    tb_clk_gen clk_gen_i (.clk_o(clk_i), .rst_no(rst_ni));

    trace_debugger dut_i (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .inst_i               (inst_i),
        .trap_i               (trap_i),
        .encapsulator_ready_i (encapsulator_ready_i),
        .lossless_trace_i     (lossless_trace_i),
        .packet_valid_o       (packet_valid_o),
        .packet_o             (packet_o),
        .stall_o              (stall_o)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        int b;
        v = '0;
        for (b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // distinct cause and tval per row and per privilege
    function automatic trdb_trap_csr_t trap_for_row(input int idx);
        trdb_trap_csr_t t;
        int p;
        for (p = 0; p < 4; p++) begin
            t.cause[p] = 5'(idx * 3 + p * 7 + 2);
            t.tval[p]  = 32'hc000_0000 + 32'(idx << 8) + 32'(p);
        end
        return t;
    endfunction

    function automatic logic is_updiscon(input logic [31:0] inst);
        return inst[6:0] == 7'b1100111 || inst == OP_MRET ||
               inst == 32'h1020_0073 || inst == 32'h0020_0073;
    endfunction

    task automatic add_row(input logic [31:0] inst, input logic [31:0] pc,
                           input logic [1:0] priv, input logic exc, input logic intr);
        rows.push_back('{inst: inst, pc: pc, priv: priv, exc: exc, intr: intr});
    endtask

    task automatic build_table();
        logic [31:0] pc;
        logic [31:0] r;
        int k;
        pc = 32'h0000_1000;
        // start packet, then straight-line code
        for (k = 0; k < 4; k++) begin
            add_row(OP_NOP, pc, 2'd3, 1'b0, 1'b0);
            pc = pc + 4;
        end
        // three branches, middle one taken, then jalr
        add_row(OP_BEQ, pc, 2'd3, 1'b0, 1'b0);
        pc = pc + 4;
        add_row(OP_BEQ, pc, 2'd3, 1'b0, 1'b0);
        pc = pc + 32'h30;
        add_row(OP_BEQ, pc, 2'd3, 1'b0, 1'b0);
        pc = pc + 4;
        add_row(OP_JALR, pc, 2'd3, 1'b0, 1'b0);
        // jalr with an empty map
        add_row(OP_JALR, 32'h0000_2000, 2'd3, 1'b0, 1'b0);
        add_row(OP_NOP, 32'h0000_3000, 2'd3, 1'b0, 1'b0);
        // s-mode exception, m-mode handler
        add_row(OP_NOP, 32'h0000_3004, 2'd1, 1'b0, 1'b0);
        add_row(OP_NOP, 32'h0000_3008, 2'd1, 1'b1, 1'b0);
        add_row(OP_NOP, 32'h0000_4000, 2'd3, 1'b0, 1'b0);
        // u-mode interrupt
        add_row(OP_NOP, 32'h0000_4004, 2'd0, 1'b0, 1'b0);
        add_row(OP_NOP, 32'h0000_4008, 2'd0, 1'b1, 1'b1);
        add_row(OP_MRET, 32'h0000_5000, 2'd3, 1'b0, 1'b0);
        // m-mode trap with an m-mode handler, no privilege change
        add_row(OP_NOP, 32'h0000_5004, 2'd3, 1'b1, 1'b0);
        add_row(OP_NOP, 32'h0000_5100, 2'd3, 1'b0, 1'b0);
        // trap from privilege level 2
        add_row(OP_NOP, 32'h0000_5104, 2'd2, 1'b0, 1'b0);
        add_row(OP_NOP, 32'h0000_5108, 2'd2, 1'b1, 1'b0);
        add_row(OP_NOP, 32'h0000_5ffc, 2'd3, 1'b0, 1'b0);
        pc = 32'h0000_6000;
        // long straight run for the resync
        for (k = 0; k < 20; k++) begin
            add_row(OP_NOP, pc, 2'd3, 1'b0, 1'b0);
            pc = pc + 4;
        end
        // 31 branches in a row, resync packets break up the run
        for (k = 0; k < 31; k++) begin
            rand_bits(1, r);
            add_row(OP_BEQ, pc, 2'd3, 1'b0, 1'b0);
            pc = r[0] ? pc + 32'h40 : pc + 4;
        end
        add_row(OP_JALR, pc, 2'd3, 1'b0, 1'b0);
        add_row(OP_NOP, 32'h0000_8000, 2'd3, 1'b0, 1'b0);
        add_row(OP_NOP, 32'h0000_8004, 2'd3, 1'b0, 1'b0);
    endtask

    // row n is decided once row n+1 has arrived
    task automatic build_expected();
        trdb_packet_t   e;
        trdb_trap_csr_t tr;
        logic [30:0]    map;
        int             count, cnt, n;
        logic           emit, sync;
        map = '0;
        count = 0;
        cnt = 0;
        for (n = 0; n + 1 < rows.size(); n++) begin
            if (rows[n].inst[6:0] == 7'b1100011) begin
                map[count] = rows[n + 1].pc == rows[n].pc + 4;
                count++;
            end
            e = '0;
            emit = 1'b1;
            sync = n == 0 || cnt == `TRDB_RESYNC_MAX ||
                   (n > 0 && (rows[n - 1].exc || rows[n - 1].priv != rows[n].priv));
            if (sync) begin
                e.format = F_SYNC;
                e.sub = (n > 0 && rows[n - 1].exc) ? SF_EXCEPTION : SF_START;
                e.payload[3:2] = e.sub;
                e.payload[5:4] = rows[n].priv;
                e.payload[37:6] = rows[n].pc;
                e.length = `TRDB_LEN_START;
                if (e.sub == SF_EXCEPTION) begin
                    tr = trap_for_row(n - 1);
                    e.payload[42:38] = tr.cause[rows[n - 1].priv];
                    e.payload[43] = rows[n - 1].intr;
                    e.payload[75:44] = tr.tval[rows[n - 1].priv];
                    e.length = `TRDB_LEN_EXC;
                end
            end else if ((n > 0 && is_updiscon(rows[n - 1].inst) && count != 0) ||
                         count == `TRDB_BMAP_LEN) begin
                e.format = F_BRANCH_FULL;
                e.payload[6:2] = 5'(count);
                e.payload[37:7] = map;
                e.payload[69:38] = rows[n].pc;
                e.length = `TRDB_LEN_BFULL;
            end else if (n > 0 && is_updiscon(rows[n - 1].inst)) begin
                e.format = F_ADDR_ONLY;
                e.payload[33:2] = rows[n].pc;
                e.length = `TRDB_LEN_ADDR;
            end else begin
                emit = 1'b0;
            end
            e.payload[1:0] = e.format;
            if (emit) begin
                exp_q.push_back(e);
                map = '0;
                count = 0;
            end
            if (emit && sync) cnt = 0;
            else if (cnt != `TRDB_RESYNC_MAX) cnt++;
        end
    endtask

    task automatic check_format(input trdb_format_e got, input trdb_format_e exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %0t packet_o.format got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_sub(input trdb_sync_sub_e got, input trdb_sync_sub_e exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %0t packet_o.sub got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_length(input logic [`TRDB_P_LEN-1:0] got,
                                input logic [`TRDB_P_LEN-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %0t packet_o.length got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_payload(input logic [`TRDB_PAYLOAD_LEN-1:0] got,
                                 input logic [`TRDB_PAYLOAD_LEN-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %0t packet_o.payload got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %0t stall_o got %b expected %b", $time, got, exp);
        end
    endtask

    // outputs sampled mid-cycle
    initial begin
        trdb_packet_t e;
        forever begin
            @(negedge clk_i);
            check_stall(stall_o, lossless_trace_i && !encapsulator_ready_i);
            if (packet_valid_o) begin
                if (exp_q.size() == 0) begin
                    unexpected++;
                    $display("%0t: packet_valid_o pulsed with no packet expected", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_format(packet_o.format, e.format);
                    check_sub(packet_o.sub, e.sub);
                    check_length(packet_o.length, e.length);
                    check_payload(packet_o.payload, e.payload);
                end
            end
        end
    end

    // 40 cycles per row plus reset
    initial begin
        wait (table_ready);
        #((rows.size() * 40 + 20) * 10);
        $display("watchdog expired before the table was fully applied");
        $display("tests failed");
        $finish;
    end

    initial begin
        trdb_inst_t  w;
        logic [31:0] r;
        int          i, gap;
        logic        sent;
        inst_i = '0;
        trap_i = '0;
        encapsulator_ready_i = 1'b1;
        lossless_trace_i = 1'b0;
        lfsr_state = 32'haecf3ee9;
        build_table();
        build_expected();
        table_ready = 1'b1;
        @(posedge rst_ni);
        for (i = 0; i < rows.size(); i++) begin
            rand_bits(2, r);
            gap = r;
            sent = 1'b0;
            while (!sent) begin
                @(posedge clk_i);
                rand_bits(2, r);
                lossless_trace_i <= r[0];
                encapsulator_ready_i <= r[1];
                // core withholds instructions on a gap or a stall
                if (gap != 0 || (r[0] && !r[1])) begin
                    inst_i <= '0;
                    if (gap != 0) gap--;
                end else begin
                    w = '0;
                    w.valid = 1'b1;
                    w.iretired = 1'b1;
                    w.exception = rows[i].exc;
                    w.interrupt = rows[i].intr;
                    w.priv = rows[i].priv;
                    w.inst_data = rows[i].inst;
                    w.pc = rows[i].pc;
                    inst_i <= w;
                    trap_i <= trap_for_row(i);
                    sent = 1'b1;
                end
            end
        end
        @(posedge clk_i);
        inst_i <= '0;
        // last packet shows two cycles after the final accept
        repeat (4) @(posedge clk_i);
        missing = exp_q.size();
        if (missing != 0) begin
            $display("%0d expected packets never appeared on packet_o", missing);
        end
        $display("value errors %0d, unexpected packets %0d, missing packets %0d",
                 value_errs, unexpected, missing);
        if (value_errs == 0 && unexpected == 0 && missing == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- trace_debugger.sv
// trace encoder top, stage chain wiring and the stall request
`include "trdb_consts.svh"

module trace_debugger (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  trdb_pkg::trdb_inst_t     inst_i,
    input  trdb_pkg::trdb_trap_csr_t trap_i,
    input  logic                     encapsulator_ready_i,
    input  logic                     lossless_trace_i,
    output logic                     packet_valid_o,
    output trdb_pkg::trdb_packet_t   packet_o,
    output logic                     stall_o
);

    // window
    trdb_pkg::trdb_stage_t       nc, tc, lc;
    logic                        first;
    logic                        decide;
    // instruction kind
    trdb_pkg::trdb_itype_e       tc_itype;
    logic                        tc_taken;
    logic                        lc_updiscon;
    // branch map and resync
    logic [`TRDB_BMAP_LEN-1:0]   map;
    logic [`TRDB_BCOUNT_LEN-1:0] count;
    logic                        full;
    logic                        resync;
    // format decision
    logic                        emit;
    trdb_pkg::trdb_format_e      format;
    trdb_pkg::trdb_sync_sub_e    sub;
    logic                        flush;

    trdb_stage_pipe i_stage_pipe (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .inst_i   (inst_i),
        .trap_i   (trap_i),
        .nc_o     (nc),
        .tc_o     (tc),
        .lc_o     (lc),
        .first_o  (first),
        .decide_o (decide)
    );

    trdb_itype_detector i_itype_detector (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .accept_i      (inst_i.valid && inst_i.iretired),
        .tc_i          (tc),
        .nc_i          (nc),
        .tc_itype_o    (tc_itype),
        .tc_taken_o    (tc_taken),
        .lc_updiscon_o (lc_updiscon)
    );

    trdb_branch_map i_branch_map (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .decide_i    (decide),
        .is_branch_i (tc_itype == trdb_pkg::IT_BRANCH),
        .taken_i     (tc_taken),
        .flush_i     (flush),
        .map_o       (map),
        .count_o     (count),
        .full_o      (full)
    );

    // restarts on every sync packet
    trdb_resync_counter i_resync_counter (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .decide_i (decide),
        .sync_i   (emit && (format == trdb_pkg::F_SYNC)),
        .resync_o (resync)
    );

    trdb_priority i_priority (
        .decide_i      (decide),
        .first_i       (first),
        .lc_i          (lc),
        .tc_i          (tc),
        .lc_updiscon_i (lc_updiscon),
        .count_i       (count),
        .full_i        (full),
        .resync_i      (resync),
        .emit_o        (emit),
        .format_o      (format),
        .sub_o         (sub),
        .flush_o       (flush)
    );

    trdb_packet_emitter i_packet_emitter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .emit_i         (emit),
        .format_i       (format),
        .sub_i          (sub),
        .lc_i           (lc),
        .tc_i           (tc),
        .map_i          (map),
        .count_i        (count),
        .packet_valid_o (packet_valid_o),
        .packet_o       (packet_o)
    );

    // core holds back instructions while the encapsulator is busy
    assign stall_o = lossless_trace_i && !encapsulator_ready_i;

endmodule

//--- trdb_branch_map.sv
// branch outcome map with branch count and full flag
// tc branch included combinationally, stored or flushed on decide
`include "trdb_consts.svh"

module trdb_branch_map (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        decide_i,
    input  logic                        is_branch_i,
    input  logic                        taken_i,
    input  logic                        flush_i,
    output logic [`TRDB_BMAP_LEN-1:0]   map_o,
    output logic [`TRDB_BCOUNT_LEN-1:0] count_o,
    output logic                        full_o
);
    import trdb_pkg::*;

    logic [`TRDB_BMAP_LEN-1:0]   map_q;
    logic [`TRDB_BCOUNT_LEN-1:0] count_q;

    // map and count as they stand with the pending branch in
    always_comb begin
        map_o   = map_q;
        count_o = count_q;
        if (decide_i && is_branch_i) begin
            // 1 means not taken, next free slot is at count
            map_o[count_q] = !taken_i;
            count_o        = count_q + 1'b1;
        end
    end

    assign full_o = count_o == `TRDB_BMAP_LEN;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (decide_i) begin
            if (flush_i) begin
                // contents went out in the packet
                map_q   <= '0;
                count_q <= '0;
            end else begin
                map_q   <= map_o;
                count_q <= count_o;
            end
        end
    end

endmodule

//--- trdb_consts.svh
// trace encoder widths, packet lengths in bytes and the resync limit
`ifndef TRDB_CONSTS_SVH
`define TRDB_CONSTS_SVH

// core side widths
`define TRDB_XLEN        32
`define TRDB_CAUSE_LEN   5
`define TRDB_PRIV_LEN    2
`define TRDB_INST_LEN    32

// branch map depth and its count width
`define TRDB_BMAP_LEN    31
`define TRDB_BCOUNT_LEN  5

// packet payload and length field
`define TRDB_PAYLOAD_LEN 96
`define TRDB_P_LEN       4

// decided instructions between forced sync packets
`define TRDB_RESYNC_MAX  16

// payload lengths per format, in bytes
`define TRDB_LEN_START   5
`define TRDB_LEN_EXC     10
`define TRDB_LEN_ADDR    5
`define TRDB_LEN_BFULL   9

`endif

//--- trdb_itype_detector.sv
// tc instruction classification and branch direction
// lc uninferable discontinuity flag
module trdb_itype_detector (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  accept_i,
    input  trdb_pkg::trdb_stage_t tc_i,
    input  trdb_pkg::trdb_stage_t nc_i,
    output trdb_pkg::trdb_itype_e tc_itype_o,
    output logic                  tc_taken_o,
    output logic                  lc_updiscon_o
);
    import trdb_pkg::*;

    logic lc_updiscon_q;

    always_comb begin
        tc_itype_o = IT_OTHER;
        if (tc_i.valid) begin
            if (tc_i.inst_data[6:0] == 7'b1100011) begin
                tc_itype_o = IT_BRANCH;
            end else if (tc_i.inst_data[6:0] == 7'b1100111) begin
                // jalr target is not inferable
                tc_itype_o = IT_UPDISCON;
            end else if (tc_i.inst_data == 32'h3020_0073 ||
                         tc_i.inst_data == 32'h1020_0073 ||
                         tc_i.inst_data == 32'h0020_0073) begin
                // mret, sret, uret
                tc_itype_o = IT_UPDISCON;
            end
        end
    end

    // no compressed instructions, fall through is always pc + 4
    assign tc_taken_o = nc_i.pc != (tc_i.pc + 32'd4);

    // flag moves to lc together with the instruction
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lc_updiscon_q <= 1'b0;
        end else if (accept_i) begin
            lc_updiscon_q <= tc_itype_o == IT_UPDISCON;
        end
    end

    assign lc_updiscon_o = lc_updiscon_q;

endmodule

//--- trdb_packet_emitter.sv
// payload packing per format, length from the format
// registered packet and one cycle valid pulse
`include "trdb_consts.svh"

module trdb_packet_emitter (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         emit_i,
    input  trdb_pkg::trdb_format_e       format_i,
    input  trdb_pkg::trdb_sync_sub_e     sub_i,
    input  trdb_pkg::trdb_stage_t        lc_i,
    input  trdb_pkg::trdb_stage_t        tc_i,
    input  logic [`TRDB_BMAP_LEN-1:0]    map_i,
    input  logic [`TRDB_BCOUNT_LEN-1:0]  count_i,
    output logic                         packet_valid_o,
    output trdb_pkg::trdb_packet_t       packet_o
);
    import trdb_pkg::*;

    trdb_packet_t packet_d;
    trdb_packet_t packet_q;
    logic         valid_q;

    // fields packed from bit 0 upward, rest stays zero
    always_comb begin
        packet_d        = '0;
        packet_d.format = format_i;
        packet_d.sub    = SF_START;
        packet_d.payload[1:0] = format_i;
        case (format_i)
            F_SYNC: begin
                packet_d.sub           = sub_i;
                packet_d.payload[3:2]  = sub_i;
                packet_d.payload[5:4]  = tc_i.priv;
                packet_d.payload[37:6] = tc_i.pc;
                packet_d.length        = `TRDB_P_LEN'(`TRDB_LEN_START);
                if (sub_i == SF_EXCEPTION) begin
                    // trap info of the instruction that trapped
                    packet_d.payload[42:38] = lc_i.cause;
                    packet_d.payload[43]    = lc_i.interrupt;
                    packet_d.payload[75:44] = lc_i.tval;
                    packet_d.length         = `TRDB_P_LEN'(`TRDB_LEN_EXC);
                end
            end
            F_BRANCH_FULL: begin
                packet_d.payload[6:2]   = count_i;
                packet_d.payload[37:7]  = map_i;
                packet_d.payload[69:38] = tc_i.pc;
                packet_d.length         = `TRDB_P_LEN'(`TRDB_LEN_BFULL);
            end
            default: begin
                // address only
                packet_d.payload[33:2] = tc_i.pc;
                packet_d.length        = `TRDB_P_LEN'(`TRDB_LEN_ADDR);
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            // one cycle pulse per emission
            valid_q <= emit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (emit_i) begin
            packet_q <= packet_d;
        end
    end

    assign packet_valid_o = valid_q;
    assign packet_o       = packet_q;

endmodule

//--- trdb_pkg.sv
// packet format, subformat and instruction kind enums
// structs for core inputs, trap csrs, window entries and packets
`include "trdb_consts.svh"

package trdb_pkg;

    // packet formats kept by this encoder
    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'd1,
        F_ADDR_ONLY   = 2'd2,
        F_SYNC        = 2'd3
    } trdb_format_e;

    // sync subformats
    typedef enum logic [1:0] {
        SF_START     = 2'd0,
        SF_EXCEPTION = 2'd1
    } trdb_sync_sub_e;

    // what the tc instruction is, as far as tracing cares
    typedef enum logic [1:0] {
        IT_OTHER    = 2'd0,
        IT_BRANCH   = 2'd1,
        IT_UPDISCON = 2'd2
    } trdb_itype_e;

    // one retired instruction from the core
    typedef struct packed {
        logic                          valid;
        logic                          iretired;
        logic                          exception;
        logic                          interrupt;
        logic [`TRDB_PRIV_LEN-1:0]     priv;
        logic [`TRDB_INST_LEN-1:0]     inst_data;
        logic [`TRDB_XLEN-1:0]         pc;
    } trdb_inst_t;

    // causes and tvals, index is the privilege level
    typedef struct packed {
        logic [3:0][`TRDB_CAUSE_LEN-1:0] cause;
        logic [3:0][`TRDB_XLEN-1:0]      tval;
    } trdb_trap_csr_t;

    // one entry of the lc/tc/nc window
    typedef struct packed {
        logic                          valid;
        logic                          exception;
        logic                          interrupt;
        logic [`TRDB_PRIV_LEN-1:0]     priv;
        logic [`TRDB_CAUSE_LEN-1:0]    cause;
        logic [`TRDB_XLEN-1:0]         tval;
        logic [`TRDB_INST_LEN-1:0]     inst_data;
        logic [`TRDB_XLEN-1:0]         pc;
    } trdb_stage_t;

    // packet handed to the encapsulator
    typedef struct packed {
        trdb_format_e                  format;
        trdb_sync_sub_e                sub;
        logic [`TRDB_P_LEN-1:0]        length;
        logic [`TRDB_PAYLOAD_LEN-1:0]  payload;
    } trdb_packet_t;

endpackage

//--- trdb_priority.sv
// packet format and subformat selection for the tc instruction
// emit and branch map flush
`include "trdb_consts.svh"

module trdb_priority (
    input  logic                         decide_i,
    input  logic                         first_i,
    input  trdb_pkg::trdb_stage_t        lc_i,
    input  trdb_pkg::trdb_stage_t        tc_i,
    input  logic                         lc_updiscon_i,
    input  logic [`TRDB_BCOUNT_LEN-1:0]  count_i,
    input  logic                         full_i,
    input  logic                         resync_i,
    output logic                         emit_o,
    output trdb_pkg::trdb_format_e       format_o,
    output trdb_pkg::trdb_sync_sub_e     sub_o,
    output logic                         flush_o
);
    import trdb_pkg::*;

    logic lc_exc;
    logic privchange;
    logic sync_req;

    // lc only counts when it holds a real instruction
    assign lc_exc     = lc_i.valid && lc_i.exception;
    assign privchange = lc_i.valid && (lc_i.priv != tc_i.priv);
    assign sync_req   = first_i || lc_exc || privchange || resync_i;

    always_comb begin
        emit_o   = 1'b0;
        format_o = F_ADDR_ONLY;
        sub_o    = SF_START;
        if (sync_req) begin
            // full sync, trap info when lc trapped
            emit_o   = 1'b1;
            format_o = F_SYNC;
            sub_o    = lc_exc ? SF_EXCEPTION : SF_START;
        end else if (lc_updiscon_i) begin
            // target address, plus any pending branches
            emit_o   = 1'b1;
            format_o = (count_i != '0) ? F_BRANCH_FULL : F_ADDR_ONLY;
        end else if (full_i) begin
            emit_o   = 1'b1;
            format_o = F_BRANCH_FULL;
        end
        // nothing is decided outside the decide cycle
        if (!decide_i) begin
            emit_o = 1'b0;
        end
    end

    // every packet carries or drops the map
    assign flush_o = emit_o;

endmodule

//--- trdb_resync_counter.sv
// counter of decided instructions since the last sync packet
`include "trdb_consts.svh"

module trdb_resync_counter (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic decide_i,
    input  logic sync_i,
    output logic resync_o
);
    import trdb_pkg::*;

    logic [$clog2(`TRDB_RESYNC_MAX + 1)-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (decide_i) begin
            if (sync_i) begin
                cnt_q <= '0;
            end else if (cnt_q != `TRDB_RESYNC_MAX) begin
                // saturate until the sync goes out
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign resync_o = cnt_q == `TRDB_RESYNC_MAX;

endmodule

//--- trdb_stage_pipe.sv
// trap cause/tval select by privilege, trace activation
// lc/tc/nc instruction window and the decide strobe
`include "trdb_consts.svh"

module trdb_stage_pipe (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  trdb_pkg::trdb_inst_t    inst_i,
    input  trdb_pkg::trdb_trap_csr_t trap_i,
    output trdb_pkg::trdb_stage_t   nc_o,
    output trdb_pkg::trdb_stage_t   tc_o,
    output trdb_pkg::trdb_stage_t   lc_o,
    output logic                    first_o,
    output logic                    decide_o
);
    import trdb_pkg::*;

    logic                       accept;
    logic [`TRDB_CAUSE_LEN-1:0] cause;
    logic [`TRDB_XLEN-1:0]      tval;
    trdb_stage_t                nc_d;
    trdb_stage_t                nc_q, tc_q, lc_q;
    logic                       trace_activated;
    logic                       nc_first_q, tc_first_q;
    logic                       decide_q;

    // window only moves on a retired instruction
    assign accept = inst_i.valid && inst_i.iretired;

    // m, vs, s, u
    always_comb begin
        case (inst_i.priv)
            2'b11: begin
                cause = trap_i.cause[3];
                tval  = trap_i.tval[3];
            end
            2'b10: begin
                cause = trap_i.cause[2];
                tval  = trap_i.tval[2];
            end
            2'b01: begin
                cause = trap_i.cause[1];
                tval  = trap_i.tval[1];
            end
            default: begin
                cause = trap_i.cause[0];
                tval  = trap_i.tval[0];
            end
        endcase
    end

    // new nc entry
    always_comb begin
        nc_d           = '0;
        nc_d.valid     = 1'b1;
        nc_d.exception = inst_i.exception;
        nc_d.interrupt = inst_i.interrupt;
        nc_d.priv      = inst_i.priv;
        nc_d.cause     = cause;
        nc_d.tval      = tval;
        nc_d.inst_data = inst_i.inst_data;
        nc_d.pc        = inst_i.pc;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            nc_q            <= '0;
            tc_q            <= '0;
            lc_q            <= '0;
            trace_activated <= 1'b0;
            nc_first_q      <= 1'b0;
            tc_first_q      <= 1'b0;
            decide_q        <= 1'b0;
        end else begin
            // tc gets a valid entry exactly when nc held one
            decide_q <= accept && nc_q.valid;
            if (accept) begin
                lc_q            <= tc_q;
                tc_q            <= nc_q;
                nc_q            <= nc_d;
                trace_activated <= 1'b1;
                // first marker follows its instruction down the window
                nc_first_q      <= !trace_activated;
                tc_first_q      <= nc_first_q;
            end
        end
    end

    assign nc_o     = nc_q;
    assign tc_o     = tc_q;
    assign lc_o     = lc_q;
    assign first_o  = tc_first_q;
    assign decide_o = decide_q;

endmodule
